//--- testbench/ula_fl_cases.txt
// Columns: opcode in1 in2 expected_out expected_is_zero, all in hex
// Word is sign, 8-bit exponent, 23-bit mantissa; zero word is 40000000
00 00000000 00000001 75400000 0
00 00000000 00000000 40000000 1
01 82900000 00000000 81C00000 0
02 00200000 00100000 7FE00000 0
02 01400000 00400000 01500000 0
02 00400000 01400000 01500000 0
02 00100000 80300000 FFC00000 0
03 00400000 80400000 8B400000 0
03 4E400000 4E400000 40000000 1
04 82300000 00C00000 F6600000 0
06 00000000 00900000 FFC00000 0
08 00000000 82900000 01C00000 0
09 00000000 80C00000 40000000 1
09 00000000 01400000 01400000 0
0A 82300000 00C00000 80C00000 0
0F 00100000 00300000 75400000 0
10 00100000 00300000 40000000 1
10 00100000 80300000 75400000 0
11 01400000 01400000 75400000 0
11 01400000 01500000 40000000 1
12 00000000 40000000 75400000 0
13 01400000 40000000 40000000 1
14 40000000 01400000 75400000 0
05 01400000 01400000 40000000 1

//--- tb.f
design/ula_fl_pkg.sv
design/fl_align_path.sv
design/fl_direct_path.sv
design/fl_normalize.sv
design/fl_result_combine.sv
design/ula_fl.sv
testbench/tb_ula_fl.sv

//--- Makefile
# Verilator build and run for the floating-point ALU testbench

VERILATOR  ?= verilator
TOP        ?= tb_ula_fl
RTL_TOP    ?= ula_fl
FILELIST   ?= tb.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= Simulation completed successfully

RTL_SRCS := $(wildcard design/*.sv)
TB_SRCS  := $(wildcard testbench/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(RTL_SRCS) $(TB_SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	@result="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$result"; \
	echo "$$result" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) design/ula_fl_pkg.sv $(filter-out design/ula_fl_pkg.sv,$(RTL_SRCS)) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/tb_ula_fl.sv
// Testbench for ula_fl, cases come from testbench/ula_fl_cases.txt
// Run from the project root so the relative case file path resolves
// Expected values in the case file are worked out by hand, up to 64 cases
module tb_ula_fl;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int clk_period  = 10;
	localparam int drive_delay = 1;
	localparam int max_cases   = 64;
	localparam int lcg_seed    = 58;

	// DUT ports
	logic                          clk;
	logic                          rst_n;
	logic                          in_valid;
	logic [ula_fl_pkg::op_w-1:0]   op;
	logic [ula_fl_pkg::word_w-1:0] in1;
	logic [ula_fl_pkg::word_w-1:0] in2;
	logic                          out_valid;
	logic [ula_fl_pkg::word_w-1:0] out;
	logic                          is_zero;

	// Case table
	logic [ula_fl_pkg::op_w-1:0]   case_op   [max_cases];
	logic [ula_fl_pkg::word_w-1:0] case_in1  [max_cases];
	logic [ula_fl_pkg::word_w-1:0] case_in2  [max_cases];
	logic [ula_fl_pkg::word_w-1:0] case_out  [max_cases];
	logic                          case_zero [max_cases];

	int          num_cases;
	logic        cases_loaded;
	int          error_count;
	int          case_errors;
	int          failed_cases;
	logic [31:0] lcg_state;

	ula_fl ula_fl_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.op        (op),
		.in1       (in1),
		.in2       (in2),
		.out_valid (out_valid),
		.out       (out),
		.is_zero   (is_zero)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Worst case per entry is 3 cycles, 4 leaves margin for reset
	initial begin
		wait (cases_loaded);
		#((num_cases * 4 + 20) * clk_period);
		$display("Timeout: the run did not finish %0d cases in the expected time", num_cases);
		$display("Simulation failed");
		$finish;
	end

	// ********************
	// Helpers
	// ********************

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1103515245 + 32'd12345;
	endfunction

	task automatic check_word(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("ERROR time=%0t signal=%s expected=%h actual=%h",
				$time, name, expected, actual);
			case_errors++;
		end
	endtask

	task automatic check_bit(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("ERROR time=%0t signal=%s expected=%b actual=%b",
				$time, name, expected, actual);
			case_errors++;
		end
	endtask

	// Lines starting with // are comments, blank lines are skipped
	task automatic load_cases(output int count, output int bad_lines, output logic opened);
		int                          fd;
		int                          n;
		string                       line;
		logic [ula_fl_pkg::op_w-1:0] f_op;
		logic [31:0]                 f_in1;
		logic [31:0]                 f_in2;
		logic [31:0]                 f_out;
		logic                        f_zero;
		count     = 0;
		bad_lines = 0;
		fd        = $fopen("testbench/ula_fl_cases.txt", "r");
		opened    = (fd != 0);
		if (opened) begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() < 2 || line.substr(0, 1) == "//") begin
					continue;
				end
				n = $sscanf(line, "%h %h %h %h %h", f_op, f_in1, f_in2, f_out, f_zero);
				if (n != 5) begin
					$display("Case file line does not hold five hex fields: %s", line);
					bad_lines++;
				end else if (count >= max_cases) begin
					$display("Case file holds more than %0d cases", max_cases);
					bad_lines++;
				end else begin
					case_op[count]   = f_op;
					case_in1[count]  = f_in1;
					case_in2[count]  = f_in2;
					case_out[count]  = f_out;
					case_zero[count] = f_zero;
					count++;
				end
			end
			$fclose(fd);
		end
	endtask

	// ********************
	// Main sequence
	// ********************

	initial begin
		int   idle;
		int   bad_lines;
		logic opened;
		rst_n        = 1'b0;
		in_valid     = 1'b0;
		op           = '0;
		in1          = '0;
		in2          = '0;
		cases_loaded = 1'b0;
		error_count  = 0;
		case_errors  = 0;
		failed_cases = 0;
		lcg_state    = lcg_seed;

		// An unreadable or empty case file counts as one error
		load_cases(num_cases, bad_lines, opened);
		if (!opened || num_cases == 0) begin
			$display("No cases could be read from testbench/ula_fl_cases.txt");
			bad_lines++;
		end
		error_count  = bad_lines;
		cases_loaded = 1'b1;

		// Two cycles of reset, released just after an edge
		repeat (2) @(posedge clk);
		#drive_delay;
		rst_n = 1'b1;

		check_bit("out_valid", 1'b0, out_valid);
		check_bit("is_zero", 1'b1, is_zero);
		check_word("out", ula_fl_pkg::zero_word, out);
		$display("reset state: %s", (case_errors == 0) ? "ok" : "mismatch");
		error_count += case_errors;

		for (int i = 0; i < num_cases; i++) begin
			case_errors = 0;
			in_valid    = 1'b1;
			op          = case_op[i];
			in1         = case_in1[i];
			in2         = case_in2[i];

			// Fixed latency of one cycle
			@(posedge clk);
			#drive_delay;
			in_valid = 1'b0;
			check_bit("out_valid", 1'b1, out_valid);
			check_word("out", case_out[i], out);
			check_bit("is_zero", case_zero[i], is_zero);

			// Idle gap, out and is_zero must hold
			lcg_state = lcg_next(lcg_state);
			idle      = int'((lcg_state >> 16) % 32'd3);
			repeat (idle) begin
				@(posedge clk);
				#drive_delay;
				check_bit("out_valid", 1'b0, out_valid);
				check_word("out", case_out[i], out);
				check_bit("is_zero", case_zero[i], is_zero);
			end

			$display("case %0d op %02h in1 %h in2 %h: %s, %0d idle cycles", i + 1,
				case_op[i], case_in1[i], case_in2[i],
				(case_errors == 0) ? "ok" : "mismatch", idle);
			if (case_errors != 0) begin
				failed_cases++;
			end
			error_count += case_errors;
		end

		$display("cases %0d, passed %0d, failed %0d, errors %0d", num_cases,
			num_cases - failed_cases, failed_cases, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- design/ula_fl.sv
// Floating-point ALU top, one registered output stage
// A new operation may enter on every cycle, result one cycle later
module ula_fl (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          in_valid,
	input  logic [ula_fl_pkg::op_w-1:0]   op,
	input  logic [ula_fl_pkg::word_w-1:0] in1,
	input  logic [ula_fl_pkg::word_w-1:0] in2,
	output logic                          out_valid,
	output logic [ula_fl_pkg::word_w-1:0] out,
	output logic                          is_zero
);

	// Aligned path results
	logic [ula_fl_pkg::word_w-1:0] sum_word;
	logic [ula_fl_pkg::word_w-1:0] les_word;
	logic [ula_fl_pkg::word_w-1:0] gre_word;

	// Direct path results
	logic [ula_fl_pkg::word_w-1:0] mul_word;
	logic [ula_fl_pkg::word_w-1:0] div_word;
	logic [ula_fl_pkg::word_w-1:0] neg_word;
	logic [ula_fl_pkg::word_w-1:0] abs_word;
	logic [ula_fl_pkg::word_w-1:0] pst_word;
	logic [ula_fl_pkg::word_w-1:0] sgn_word;
	logic [ula_fl_pkg::word_w-1:0] equ_word;
	logic [ula_fl_pkg::word_w-1:0] lin_word;
	logic [ula_fl_pkg::word_w-1:0] lan_word;
	logic [ula_fl_pkg::word_w-1:0] lor_word;

	// Both paths see the same operands
	fl_align_path fl_align_path_i (
		.in1      (in1),
		.in2      (in2),
		.sum_word (sum_word),
		.les_word (les_word),
		.gre_word (gre_word)
	);

	fl_direct_path fl_direct_path_i (
		.in1      (in1),
		.in2      (in2),
		.mul_word (mul_word),
		.div_word (div_word),
		.neg_word (neg_word),
		.abs_word (abs_word),
		.pst_word (pst_word),
		.sgn_word (sgn_word),
		.equ_word (equ_word),
		.lin_word (lin_word),
		.lan_word (lan_word),
		.lor_word (lor_word)
	);

	// Select, normalize, register
	fl_result_combine fl_result_combine_i (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.op        (op),
		.in1       (in1),
		.in2       (in2),
		.sum_word  (sum_word),
		.les_word  (les_word),
		.gre_word  (gre_word),
		.mul_word  (mul_word),
		.div_word  (div_word),
		.neg_word  (neg_word),
		.abs_word  (abs_word),
		.pst_word  (pst_word),
		.sgn_word  (sgn_word),
		.equ_word  (equ_word),
		.lin_word  (lin_word),
		.lan_word  (lan_word),
		.lor_word  (lor_word),
		.out_valid (out_valid),
		.out       (out),
		.is_zero   (is_zero)
	);

endmodule

//--- design/fl_result_combine.sv
// Selects one result by opcode, normalizes it and registers it
// Fixed latency of one cycle, no back-pressure
// out holds its last value while in_valid is low
module fl_result_combine (
	input  logic                          clk,
	input  logic                          rst_n,
	input  logic                          in_valid,
	input  logic [ula_fl_pkg::op_w-1:0]   op,
	input  logic [ula_fl_pkg::word_w-1:0] in1,
	input  logic [ula_fl_pkg::word_w-1:0] in2,
	input  logic [ula_fl_pkg::word_w-1:0] sum_word,
	input  logic [ula_fl_pkg::word_w-1:0] les_word,
	input  logic [ula_fl_pkg::word_w-1:0] gre_word,
	input  logic [ula_fl_pkg::word_w-1:0] mul_word,
	input  logic [ula_fl_pkg::word_w-1:0] div_word,
	input  logic [ula_fl_pkg::word_w-1:0] neg_word,
	input  logic [ula_fl_pkg::word_w-1:0] abs_word,
	input  logic [ula_fl_pkg::word_w-1:0] pst_word,
	input  logic [ula_fl_pkg::word_w-1:0] sgn_word,
	input  logic [ula_fl_pkg::word_w-1:0] equ_word,
	input  logic [ula_fl_pkg::word_w-1:0] lin_word,
	input  logic [ula_fl_pkg::word_w-1:0] lan_word,
	input  logic [ula_fl_pkg::word_w-1:0] lor_word,
	output logic                          out_valid,
	output logic [ula_fl_pkg::word_w-1:0] out,
	output logic                          is_zero
);

	logic [ula_fl_pkg::word_w-1:0] sel_word;
	logic [ula_fl_pkg::word_w-1:0] norm_word;
	logic [ula_fl_pkg::word_w-1:0] out_q;

	// ********************
	// Opcode select
	// ********************

	always_comb begin
		case (op)
			ula_fl_pkg::op_nop:  sel_word = in2;
			ula_fl_pkg::op_load: sel_word = in1;
			ula_fl_pkg::op_add:  sel_word = sum_word;
			ula_fl_pkg::op_mlt:  sel_word = mul_word;
			ula_fl_pkg::op_div:  sel_word = div_word;
			ula_fl_pkg::op_neg:  sel_word = neg_word;
			ula_fl_pkg::op_abs:  sel_word = abs_word;
			ula_fl_pkg::op_pst:  sel_word = pst_word;
			ula_fl_pkg::op_sgn:  sel_word = sgn_word;
			ula_fl_pkg::op_les:  sel_word = les_word;
			ula_fl_pkg::op_gre:  sel_word = gre_word;
			ula_fl_pkg::op_equ:  sel_word = equ_word;
			ula_fl_pkg::op_lin:  sel_word = lin_word;
			ula_fl_pkg::op_lan:  sel_word = lan_word;
			ula_fl_pkg::op_lor:  sel_word = lor_word;
			// Unused slot
			default:             sel_word = ula_fl_pkg::zero_word;
		endcase
	end

	// Every result, pass-through included, leaves normalized
	fl_normalize fl_normalize_i (
		.raw_word  (sel_word),
		.norm_word (norm_word)
	);

	// ********************
	// Output register
	// ********************

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			out_q     <= ula_fl_pkg::zero_word;
		end else begin
			out_valid <= in_valid;
			if (in_valid) begin
				out_q <= norm_word;
			end
		end
	end

	assign out     = out_q;
	// Taken from the register, so it follows out exactly
	assign is_zero = (out_q == ula_fl_pkg::zero_word);

endmodule

//--- design/fl_normalize.sv
// Combinational, shifts the mantissa left until bit 22 is set
// A zero mantissa yields zero_word, its sign is dropped
module fl_normalize (
	input  logic [ula_fl_pkg::word_w-1:0] raw_word,
	output logic [ula_fl_pkg::word_w-1:0] norm_word
);

	ula_fl_pkg::fl_word_u in_u;
	ula_fl_pkg::fl_word_u out_u;

	// Leading zero count as a plain integer
	int                                lz;
	logic [ula_fl_pkg::exp_w-1:0]      shamt;
	logic                              man_zero;

	assign in_u = raw_word;

	// Priority chain, the highest set bit wins
	always_comb begin
		lz = 0;
		for (int i = 0; i < ula_fl_pkg::man_w; i++) begin
			if (in_u.fields.man[i]) begin
				lz = ula_fl_pkg::man_w - 1 - i;
			end
		end
	end

	assign shamt    = lz[ula_fl_pkg::exp_w-1:0];
	assign man_zero = (in_u.fields.man == '0);

	always_comb begin
		if (man_zero) begin
			out_u.raw = ula_fl_pkg::zero_word;
		end else begin
			out_u.fields.sign = in_u.fields.sign;
			// Exponent drops by the shift, wraps like every exponent here
			out_u.fields.exp  = in_u.fields.exp - shamt;
			out_u.fields.man  = in_u.fields.man << shamt;
		end
	end

	assign norm_word = out_u.raw;

endmodule

//--- design/fl_direct_path.sv
// Combinational, works on raw fields without alignment
// DIV by a zero mantissa gives an undefined mantissa
// MLT detects underflow only, an exponent overflow wraps
module fl_direct_path (
	input  logic [ula_fl_pkg::word_w-1:0] in1,
	input  logic [ula_fl_pkg::word_w-1:0] in2,
	output logic [ula_fl_pkg::word_w-1:0] mul_word,
	output logic [ula_fl_pkg::word_w-1:0] div_word,
	output logic [ula_fl_pkg::word_w-1:0] neg_word,
	output logic [ula_fl_pkg::word_w-1:0] abs_word,
	output logic [ula_fl_pkg::word_w-1:0] pst_word,
	output logic [ula_fl_pkg::word_w-1:0] sgn_word,
	output logic [ula_fl_pkg::word_w-1:0] equ_word,
	output logic [ula_fl_pkg::word_w-1:0] lin_word,
	output logic [ula_fl_pkg::word_w-1:0] lan_word,
	output logic [ula_fl_pkg::word_w-1:0] lor_word
);

	ula_fl_pkg::fl_word_u a;
	ula_fl_pkg::fl_word_u b;
	ula_fl_pkg::fl_word_u mul_u;
	ula_fl_pkg::fl_word_u div_u;

	logic signed [ula_fl_pkg::exp_w-1:0]   e1;
	logic signed [ula_fl_pkg::exp_w-1:0]   e2;
	logic        [ula_fl_pkg::man_w-1:0]   m1;
	logic        [ula_fl_pkg::man_w-1:0]   m2;

	// Multiplier
	logic        [2*ula_fl_pkg::man_w-1:0] prod;
	logic signed [ula_fl_pkg::exp_w:0]     exp_mul;
	logic                                  underflow;

	// Divider
	logic        [2*ula_fl_pkg::man_w-2:0] dividend;
	logic        [2*ula_fl_pkg::man_w-2:0] quot;

	// Zero tests on the raw view
	logic                                  in1_zero;
	logic                                  in2_zero;

	assign a = in1;
	assign b = in2;

	assign e1 = a.fields.exp;
	assign e2 = b.fields.exp;
	assign m1 = a.fields.man;
	assign m2 = b.fields.man;

	// ********************
	// MLT
	// ********************

	assign prod = {{ula_fl_pkg::man_w{1'b0}}, m1} * {{ula_fl_pkg::man_w{1'b0}}, m2};

	// Upper half of the product kept, so the exponent gains man_w
	assign exp_mul = {e1[ula_fl_pkg::exp_w-1], e1} + {e2[ula_fl_pkg::exp_w-1], e2}
		+ ula_fl_pkg::man_w[ula_fl_pkg::exp_w:0];

	// Sum below the 8-bit range
	assign underflow = (exp_mul[ula_fl_pkg::exp_w:ula_fl_pkg::exp_w-1] == 2'b10);

	always_comb begin
		mul_u.fields.sign = a.fields.sign ^ b.fields.sign;
		mul_u.fields.exp  = exp_mul[ula_fl_pkg::exp_w-1:0];
		mul_u.fields.man  = underflow ? '0 : prod[2*ula_fl_pkg::man_w-1:ula_fl_pkg::man_w];
	end

	assign mul_word = mul_u.raw;

	// ********************
	// DIV
	// ********************

	// Dividend pre-shifted by man_w-1 for quotient precision
	assign dividend = {m1, {(ula_fl_pkg::man_w-1){1'b0}}};
	assign quot     = dividend / {{(ula_fl_pkg::man_w-1){1'b0}}, m2};

	always_comb begin
		div_u.fields.sign = a.fields.sign ^ b.fields.sign;
		div_u.fields.exp  = e1 - e2 - ula_fl_pkg::man_w[ula_fl_pkg::exp_w-1:0]
			+ {{(ula_fl_pkg::exp_w-1){1'b0}}, 1'b1};
		div_u.fields.man  = quot[ula_fl_pkg::man_w-1:0];
	end

	assign div_word = div_u.raw;

	// Sign handling, all on in2
	assign neg_word = {~b.fields.sign, b.fields.exp, b.fields.man};
	assign abs_word = {1'b0, b.fields.exp, b.fields.man};
	// Negative input clears exponent and mantissa
	assign pst_word = b.fields.sign ? '0 : {1'b0, b.fields.exp, b.fields.man};
	assign sgn_word = {a.fields.sign, b.fields.exp, b.fields.man};

	// ********************
	// EQU and logic
	// ********************

	assign equ_word = (a.raw == b.raw) ? ula_fl_pkg::true_word : ula_fl_pkg::false_word;

	assign in1_zero = (a.raw == ula_fl_pkg::zero_word);
	assign in2_zero = (b.raw == ula_fl_pkg::zero_word);

	assign lin_word = in2_zero ? ula_fl_pkg::true_word : ula_fl_pkg::false_word;
	assign lan_word = (in1_zero || in2_zero) ? ula_fl_pkg::false_word : ula_fl_pkg::true_word;
	assign lor_word = (!in1_zero || !in2_zero) ? ula_fl_pkg::true_word : ula_fl_pkg::false_word;

endmodule

//--- design/fl_align_path.sv
// Combinational, aligns both operands to the larger exponent
// Mantissa bits shifted out on the smaller operand are lost
// ADD keeps one guard position, so the sum loses its lowest bit
module fl_align_path (
	input  logic [ula_fl_pkg::word_w-1:0] in1,
	input  logic [ula_fl_pkg::word_w-1:0] in2,
	output logic [ula_fl_pkg::word_w-1:0] sum_word,
	output logic [ula_fl_pkg::word_w-1:0] les_word,
	output logic [ula_fl_pkg::word_w-1:0] gre_word
);

	ula_fl_pkg::fl_word_u a;
	ula_fl_pkg::fl_word_u b;
	ula_fl_pkg::fl_word_u sum_u;

	// Operand fields
	logic signed [ula_fl_pkg::exp_w-1:0] e1;
	logic signed [ula_fl_pkg::exp_w-1:0] e2;
	logic        [ula_fl_pkg::man_w-1:0] m1;
	logic        [ula_fl_pkg::man_w-1:0] m2;

	// Alignment
	logic signed [ula_fl_pkg::exp_w:0]   exp_diff;
	logic                                in2_bigger;
	logic        [ula_fl_pkg::exp_w:0]   shift1;
	logic        [ula_fl_pkg::exp_w:0]   shift2;
	logic signed [ula_fl_pkg::exp_w-1:0] exp_big;
	logic        [ula_fl_pkg::man_w-1:0] man1_al;
	logic        [ula_fl_pkg::man_w-1:0] man2_al;

	// Signed aligned mantissas and their sum
	logic signed [ula_fl_pkg::man_w:0]   sm1;
	logic signed [ula_fl_pkg::man_w:0]   sm2;
	logic signed [ula_fl_pkg::man_w+1:0] sum;
	logic signed [ula_fl_pkg::man_w+1:0] sum_mag;

	assign a = in1;
	assign b = in2;

	assign e1 = a.fields.exp;
	assign e2 = b.fields.exp;
	assign m1 = a.fields.man;
	assign m2 = b.fields.man;

	// ********************
	// Exponent alignment
	// ********************

	// One extra bit so the difference never wraps
	assign exp_diff   = {e1[ula_fl_pkg::exp_w-1], e1} - {e2[ula_fl_pkg::exp_w-1], e2};
	assign in2_bigger = exp_diff[ula_fl_pkg::exp_w];

	// Only the operand with the smaller exponent moves
	assign shift1  = in2_bigger ? -exp_diff : '0;
	assign shift2  = in2_bigger ? '0 : exp_diff;
	assign exp_big = in2_bigger ? e2 : e1;

	assign man1_al = m1 >> shift1;
	assign man2_al = m2 >> shift2;

	// Two's complement by sign bit
	assign sm1 = a.fields.sign ? -{1'b0, man1_al} : {1'b0, man1_al};
	assign sm2 = b.fields.sign ? -{1'b0, man2_al} : {1'b0, man2_al};

	// ********************
	// Adder
	// ********************

	assign sum     = {sm1[ula_fl_pkg::man_w], sm1} + {sm2[ula_fl_pkg::man_w], sm2};
	assign sum_mag = sum[ula_fl_pkg::man_w+1] ? -sum : sum;

	// Drop the lowest bit and compensate with exponent + 1
	always_comb begin
		sum_u.fields.sign = sum[ula_fl_pkg::man_w+1];
		sum_u.fields.exp  = exp_big + {{(ula_fl_pkg::exp_w-1){1'b0}}, 1'b1};
		sum_u.fields.man  = sum_mag[ula_fl_pkg::man_w:1];
	end

	assign sum_word = sum_u.raw;

	// Ordered compares on the aligned signed mantissas
	assign les_word = (sm1 < sm2) ? ula_fl_pkg::true_word : ula_fl_pkg::false_word;
	assign gre_word = (sm1 > sm2) ? ula_fl_pkg::true_word : ula_fl_pkg::false_word;

endmodule

//--- design/ula_fl_pkg.sv
// Word format: sign, 8-bit two's-complement exponent, 23-bit mantissa without hidden bit
// Value is (-1)^sign * mantissa * 2^exponent; exponents wrap and are never limited
// Zero is the single word with sign 0, exponent 8'h80 and mantissa 0
package ula_fl_pkg;

	// ********************
	// Word geometry
	// ********************

	localparam int exp_w  = 8;
	localparam int man_w  = 23;
	localparam int word_w = exp_w + man_w + 1;

	// Opcode width, gaps in the numbering are unused slots
	localparam int op_w = 5;

	// ********************
	// Opcodes
	// ********************

	// Pass-through
	localparam logic [op_w-1:0] op_nop  = 5'd0;
	localparam logic [op_w-1:0] op_load = 5'd1;

	// Arithmetic
	localparam logic [op_w-1:0] op_add  = 5'd2;
	localparam logic [op_w-1:0] op_mlt  = 5'd3;
	localparam logic [op_w-1:0] op_div  = 5'd4;
	localparam logic [op_w-1:0] op_neg  = 5'd6;

	// Single operand sign handling
	localparam logic [op_w-1:0] op_abs  = 5'd8;
	localparam logic [op_w-1:0] op_pst  = 5'd9;
	localparam logic [op_w-1:0] op_sgn  = 5'd10;

	// Comparisons
	localparam logic [op_w-1:0] op_les  = 5'd15;
	localparam logic [op_w-1:0] op_gre  = 5'd16;
	localparam logic [op_w-1:0] op_equ  = 5'd17;

	// Logical, operands are false only when they equal zero_word
	localparam logic [op_w-1:0] op_lin  = 5'd18;
	localparam logic [op_w-1:0] op_lan  = 5'd19;
	localparam logic [op_w-1:0] op_lor  = 5'd20;

	// ********************
	// Special words
	// ********************

	// Most negative exponent, zero mantissa
	localparam logic [word_w-1:0] zero_word = {1'b0, 1'b1, {(word_w-2){1'b0}}};

	// Booleans before normalization
	localparam logic [word_w-1:0] true_word  = {{(word_w-1){1'b0}}, 1'b1};
	localparam logic [word_w-1:0] false_word = {word_w{1'b0}};

	// One word, two views
	// raw for equality and zero tests, fields for arithmetic
	typedef union packed {
		logic [word_w-1:0] raw;
		struct packed {
			logic                    sign;
			logic signed [exp_w-1:0] exp;
			logic        [man_w-1:0] man;
		} fields;
	} fl_word_u;

endpackage
